//--- Makefile
# Verilator build and run for the SPI register slave testbench.

SIM := obj_dir/Vspi_slave_tb
SRCS := $(wildcard logic/*.sv logic/*.svh dv/*.sv) files.f

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" sim.log; then echo "Simulation ended early"; exit 1; fi

$(SIM): $(SRCS)
	verilator --binary --timing --assert --top-module spi_slave_tb -f files.f

clean:
	rm -rf obj_dir sim.log

//--- dv/spi_slave_props.sv
// Concurrent checks on the SPI protocol FSM.
// Write strobe width and origin, and dropped writes to the read-only addresses.
// Bound into every spi_protocol instance.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_slave_props
  import spi_slave_pkg::*;
(
  input logic                   clk,
  input logic                   rst,
  input proto_state_t           state,
  input logic                   ss_rise,
  input reg_wr_t                wr,
  input logic [`SPI_ADDR_W-1:0] rd_addr,
  input logic [`SPI_DATA_W-1:0] rd_data
);

  // A write request is a single-cycle strobe.
  wr_one_cycle_a: assert property (@(posedge clk) disable iff (rst)
    wr.en |=> !wr.en)
    else $error("write enable stayed high for more than one cycle");

  // The strobe is raised only when a held command sees its data frame end.
  wr_origin_a: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> $past(state == proto_cmd && ss_rise))
    else $error("write enable raised outside the end of a data frame");

  // A write to the status or ID address must never reach the stored contents.
  // The value read at that address is the same before and after the strobe.
  ro_dropped_a: assert property (@(posedge clk) disable iff (rst)
    (wr.en && wr.addr >= `SPI_STATUS_ADDR && rd_addr == wr.addr) |=> $stable(rd_data))
    else $error("write to a read-only address changed its read value");

endmodule

bind spi_protocol spi_slave_props u_props (
  .clk     (clk),
  .rst     (rst),
  .state   (state),
  .ss_rise (ss_rise),
  .wr      (wr),
  .rd_addr (rd_addr),
  .rd_data (rd_data)
);

//--- dv/spi_slave_tb.sv
// Directed testbench for the SPI register slave.
// SPI mode 0 master tasks, LFSR stimulus, register model, value check and
// per-test reporting.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_slave_tb;

  // Half an sclk period, in system clocks.
  localparam int HALF = 4;
  // Upper bound on the whole run, in system clocks.
  localparam int RUN_LIMIT = 100000;
  localparam int RESET_LIMIT = 50;
  localparam int RW_N = `SPI_REG_N - 2;
  // Command bits above the read flag, which the slave ignores.
  localparam int PAD_W = `SPI_DATA_W - `SPI_ADDR_W - 1;

  logic                   clk;
  logic                   rst;
  logic                   sclk;
  logic                   ss;
  logic                   mosi;
  logic                   miso;
  logic [`SPI_DATA_W-1:0] status;

  // Expected contents of the writable registers.
  logic [`SPI_DATA_W-1:0] model [RW_N];

  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          tests;

  tb_clock_gen u_clock (
    .clk (clk),
    .rst (rst)
  );

  spi_slave_top UUT (
    .clk    (clk),
    .rst    (rst),
    .sclk   (sclk),
    .ss     (ss),
    .mosi   (mosi),
    .status (status),
    .miso   (miso)
  );

  // Galois LFSR, taps 32, 22, 2 and 1, shifting right.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken, packed in from the right.
  task automatic take_bits(input int n, output logic [`SPI_DATA_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[`SPI_DATA_W-2:0], lfsr_q[0]};
    end
  endtask

  // Random address within the writable range.
  task automatic pick_addr(output logic [`SPI_ADDR_W-1:0] a);
    logic [`SPI_DATA_W-1:0] v;
    take_bits(`SPI_ADDR_W, v);
    a = `SPI_ADDR_W'(v % RW_N);
  endtask

  task automatic check_value(input string name, input logic [`SPI_DATA_W-1:0] exp,
                             input logic [`SPI_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  // Reset comes from the clock module, so only its release is awaited.
  task automatic wait_reset_release(output bit ok);
    int n;
    n = 0;
    @(posedge clk);
    while (rst && n < RESET_LIMIT) begin
      @(posedge clk);
      n++;
    end
    ok = !rst;
    @(posedge clk);
  endtask

  // One 16-bit frame, MSB first, in mode 0.
  // The lead time after ss falls lets the slave load its word onto miso.
  // miso is taken one clock after the rising sclk, since the slave moves it
  // four clocks after each falling edge through its synchronizer.
  task automatic shift_frame(input logic [`SPI_DATA_W-1:0] tx,
                             output logic [`SPI_DATA_W-1:0] rx);
    rx = '0;
    ss   <= 1'b0;
    mosi <= tx[`SPI_DATA_W-1];
    wait_clocks(2 * HALF);
    for (int i = `SPI_DATA_W - 1; i >= 0; i--) begin
      sclk <= 1'b1;
      @(posedge clk);
      rx = {rx[`SPI_DATA_W-2:0], miso};
      wait_clocks(HALF - 1);
      sclk <= 1'b0;
      if (i > 0) begin
        mosi <= tx[i-1];
      end
      wait_clocks(HALF);
    end
    ss   <= 1'b1;
    mosi <= 1'b0;
    // Gap with ss high, long enough for the FSM to decode the frame.
    wait_clocks(2 * HALF);
  endtask

  // Command frame with random upper bits.
  // The slave sends its cleared word back during every command frame.
  task automatic send_command(input logic rd, input logic [`SPI_ADDR_W-1:0] addr);
    logic [`SPI_DATA_W-1:0] pad;
    logic [`SPI_DATA_W-1:0] echo;
    take_bits(PAD_W, pad);
    shift_frame({pad[PAD_W-1:0], rd, addr}, echo);
    check_value("miso word in command frame", '0, echo);
  endtask

  task automatic write_reg(input logic [`SPI_ADDR_W-1:0] addr,
                           input logic [`SPI_DATA_W-1:0] data);
    logic [`SPI_DATA_W-1:0] unused;
    send_command(1'b0, addr);
    shift_frame(data, unused);
  endtask

  task automatic read_reg(input logic [`SPI_ADDR_W-1:0] addr,
                          output logic [`SPI_DATA_W-1:0] data);
    send_command(1'b1, addr);
    shift_frame('0, data);
  endtask

  task automatic read_expect(input logic [`SPI_ADDR_W-1:0] addr,
                             input logic [`SPI_DATA_W-1:0] exp);
    logic [`SPI_DATA_W-1:0] got;
    read_reg(addr, got);
    check_value($sformatf("miso word of reg %0d", addr), exp, got);
  endtask

  // Write to the slave and keep the model in step.
  task automatic write_model(input logic [`SPI_ADDR_W-1:0] addr,
                             input logic [`SPI_DATA_W-1:0] data);
    write_reg(addr, data);
    if (addr < RW_N) begin
      model[addr] = data;
    end
  endtask

  task automatic read_all_model();
    for (int i = 0; i < RW_N; i++) begin
      read_expect(`SPI_ADDR_W'(i), model[i]);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic reset_values_test();
    int err0;
    err0 = errors;
    read_all_model();
    report_test("reset values", err0);
  endtask

  task automatic write_readback_test();
    int err0;
    logic [`SPI_ADDR_W-1:0] a;
    logic [`SPI_DATA_W-1:0] d;
    err0 = errors;
    for (int n = 0; n < 12; n++) begin
      pick_addr(a);
      take_bits(`SPI_DATA_W, d);
      write_model(a, d);
    end
    read_all_model();
    report_test("write then read back", err0);
  endtask

  task automatic id_register_test();
    int err0;
    err0 = errors;
    read_expect(`SPI_ID_ADDR, `SPI_ID_WORD);
    read_expect(`SPI_ID_ADDR, `SPI_ID_WORD);
    report_test("ID register", err0);
  endtask

  // Status is held from the command frame until the data word is loaded.
  task automatic status_register_test();
    int err0;
    logic [`SPI_DATA_W-1:0] s;
    err0 = errors;
    for (int n = 0; n < 3; n++) begin
      take_bits(`SPI_DATA_W, s);
      status <= s;
      @(posedge clk);
      read_expect(`SPI_STATUS_ADDR, s);
    end
    report_test("status register", err0);
  endtask

  task automatic read_only_test();
    int err0;
    logic [`SPI_ADDR_W-1:0] a;
    logic [`SPI_DATA_W-1:0] s;
    logic [`SPI_DATA_W-1:0] d;
    err0 = errors;
    take_bits(`SPI_DATA_W, s);
    status <= s;
    @(posedge clk);
    take_bits(`SPI_DATA_W, d);
    write_model(`SPI_STATUS_ADDR, d);
    take_bits(`SPI_DATA_W, d);
    write_model(`SPI_ID_ADDR, d);
    read_expect(`SPI_STATUS_ADDR, s);
    read_expect(`SPI_ID_ADDR, `SPI_ID_WORD);
    // One more write, then every other register must be as before.
    pick_addr(a);
    take_bits(`SPI_DATA_W, d);
    write_model(a, d);
    read_all_model();
    report_test("read-only registers", err0);
  endtask

  task automatic back_to_back_test();
    int err0;
    logic [`SPI_ADDR_W-1:0] a;
    logic [`SPI_ADDR_W-1:0] b;
    logic [`SPI_DATA_W-1:0] d;
    err0 = errors;
    for (int n = 0; n < 8; n++) begin
      pick_addr(a);
      take_bits(`SPI_DATA_W, d);
      write_model(a, d);
      read_expect(a, model[a]);
      pick_addr(b);
      read_expect(b, model[b]);
    end
    report_test("back-to-back transactions", err0);
  endtask

  // Stops a run that never reaches its end.
  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    $display("Simulation did not finish within %0d clocks", RUN_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    bit ok;
    sclk   = 1'b0;
    ss     = 1'b1;
    mosi   = 1'b0;
    status = '0;
    lfsr_q = 32'h9132_f503;
    errors = 0;
    checks = 0;
    tests  = 0;
    // The general registers come out of reset as zero.
    for (int i = 0; i < RW_N; i++) begin
      model[i] = '0;
    end
    wait_reset_release(ok);
    if (!ok) begin
      errors++;
      $display("Reset was never released");
    end else begin
      reset_values_test();
      write_readback_test();
      id_register_test();
      status_register_test();
      read_only_test();
      back_to_back_test();
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock_gen.sv
// Clock and reset source for the SPI slave testbench.
// 4 ns system clock, reset held high for the first two rising edges.

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // Free-running system clock.
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset drops on the second rising edge.
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- files.f
+incdir+logic
logic/spi_slave_pkg.sv
logic/spi_frame_shifter.sv
logic/spi_protocol.sv
logic/spi_reg_bank.sv
logic/spi_slave_top.sv
dv/tb_clock_gen.sv
dv/spi_slave_props.sv
dv/spi_slave_tb.sv

//--- logic/spi_frame_shifter.sv
// SPI mode 0 frame shifter.
// Synchronizes sclk, ss and mosi, detects their edges, shifts mosi into a
// receive word and shifts a transmit word out on miso, MSB first.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_frame_shifter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sclk,
  input  logic                   ss,
  input  logic                   mosi,
  input  logic [`SPI_DATA_W-1:0] tx_frame,
  output logic                   miso,
  output logic [`SPI_DATA_W-1:0] rx_frame,
  output logic                   ss_rise,
  output logic                   ss_fall
);

  // Bits 0 and 1 are the two synchronizer flops.
  // Bit 2 holds the previous synchronized value for edge detection.
  logic [2:0] sclk_q;
  logic [2:0] ss_q;
  logic [2:0] mosi_q;

  // Registered sclk edge pulses, aligned with ss_rise and ss_fall.
  logic sclk_rise;
  logic sclk_fall;

  // Edge of ss seen between the last two flops, one cycle ahead of ss_rise.
  logic ss_rise_det;

  // Chip select is active low.
  logic ss_active;

  logic [`SPI_DATA_W-1:0] rx_shift;
  logic [`SPI_DATA_W-1:0] tx_shift;

  // The SPI pins are asynchronous to clk, so each passes two flops first.
  // Chip select starts high so that reset does not look like a frame start.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_q <= 3'b000;
      ss_q   <= 3'b111;
      mosi_q <= 3'b000;
    end else begin
      sclk_q <= {sclk_q[1:0], sclk};
      ss_q   <= {ss_q[1:0], ss};
      mosi_q <= {mosi_q[1:0], mosi};
    end
  end

  assign ss_rise_det = ss_q[1] & ~ss_q[2];
  assign ss_active   = ~ss_q[2];

  // Edge pulses are registered, which puts them three clocks after the pin.
  // In the pulse cycle bit 2 of every pin holds the value of the same sample.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      ss_rise   <= 1'b0;
      ss_fall   <= 1'b0;
    end else begin
      sclk_rise <= sclk_q[1] & ~sclk_q[2];
      sclk_fall <= ~sclk_q[1] & sclk_q[2];
      ss_rise   <= ss_rise_det;
      ss_fall   <= ~ss_q[1] & ss_q[2];
    end
  end

  // Receive side.
  // Mode 0 puts data on mosi before the rising sclk edge, so it is taken then.
  always_ff @(posedge clk) begin
    if (sclk_rise && ss_active) begin
      rx_shift <= {rx_shift[`SPI_DATA_W-2:0], mosi_q[2]};
    end
  end

  // The finished word is copied one cycle before the ss_rise pulse.
  // The protocol can then use rx_frame in the same cycle as ss_rise.
  always_ff @(posedge clk) begin
    if (ss_rise_det) begin
      rx_frame <= rx_shift;
    end
  end

  // Transmit side.
  // The word is loaded at frame start so its MSB is on miso before the first
  // rising sclk edge. Each falling edge then moves the next bit up.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tx_shift <= '0;
    end else if (ss_fall) begin
      tx_shift <= tx_frame;
    end else if (sclk_fall && ss_active) begin
      tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
    end
  end

  assign miso = tx_shift[`SPI_DATA_W-1];

endmodule

//--- logic/spi_protocol.sv
// Command and data FSM of the SPI register slave.
// Decodes the command frame, returns register data for reads and issues a
// single-cycle register write at the end of a write data frame.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_protocol
  import spi_slave_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`SPI_DATA_W-1:0] rx_frame,
  input  logic                   ss_rise,
  input  logic                   ss_fall,
  input  logic [`SPI_DATA_W-1:0] rd_data,
  output logic [`SPI_DATA_W-1:0] tx_frame,
  output logic [`SPI_ADDR_W-1:0] rd_addr,
  output reg_wr_t                wr
);

  proto_state_t state;

  // Command of the transaction in progress.
  spi_cmd_t cmd;

  logic                   wr_en;
  logic [`SPI_DATA_W-1:0] wr_data;

  // The data frame ends while a command is held.
  logic data_end;

  assign data_end = (state == proto_cmd) && ss_rise;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= proto_idle;
      cmd      <= '0;
      tx_frame <= '0;
      wr_en    <= 1'b0;
    end else begin
      case (state)
        proto_idle: begin
          // A finished frame in this state is a command.
          if (ss_rise) begin
            cmd.rd   <= rx_frame[`SPI_ADDR_W];
            cmd.addr <= rx_frame[`SPI_ADDR_W-1:0];
            state    <= proto_cmd;
          end
        end
        proto_cmd: begin
          // For a read, keep tx_frame on the selected register.
          // The shifter takes whatever is here when the data frame starts.
          if (cmd.rd) begin
            tx_frame <= rd_data;
          end
          // End of the data frame. Nothing more to send, and a write
          // request goes out for one cycle.
          if (ss_rise) begin
            tx_frame <= '0;
            wr_en    <= ~cmd.rd;
            state    <= proto_data;
          end
        end
        proto_data: begin
          wr_en <= 1'b0;
          // The next chip-select fall closes the transaction.
          if (ss_fall) begin
            state <= proto_idle;
          end
        end
        default: begin
          state <= proto_idle;
        end
      endcase
    end
  end

  // Write data is only looked at while wr_en is high.
  always_ff @(posedge clk) begin
    if (data_end && !cmd.rd) begin
      wr_data <= rx_frame;
    end
  end

  // The bank reads and writes at the latched command address.
  assign rd_addr = cmd.addr;

  assign wr.en   = wr_en;
  assign wr.addr = cmd.addr;
  assign wr.data = wr_data;

endmodule

//--- logic/spi_reg_bank.sv
// Register bank of the SPI register slave.
// Holds the general read/write registers and maps the live status input and
// the fixed ID word onto the two top addresses.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_reg_bank
  import spi_slave_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  reg_wr_t                wr,
  input  logic [`SPI_ADDR_W-1:0] rd_addr,
  input  logic [`SPI_DATA_W-1:0] status,
  output logic [`SPI_DATA_W-1:0] rd_data
);

  // All registers but the status and ID slots are storage.
  localparam int unsigned RW_N = `SPI_REG_N - 2;

  logic [`SPI_DATA_W-1:0] regs [RW_N];

  // Write side is only accepted inside the storage range.
  logic wr_hit;

  assign wr_hit = wr.en && (wr.addr < RW_N);

  // Writes land on the clock edge after the request.
  // A request to the status or ID address falls outside the range and is
  // dropped here.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < RW_N; i++) begin
        regs[i] <= `SPI_REG_RST;
      end
    end else if (wr_hit) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // Reads are combinational.
  // The protocol registers the result into tx_frame, which keeps the read
  // path off the SPI timing.
  always_comb begin
    if (rd_addr == `SPI_ID_ADDR) begin
      rd_data = `SPI_ID_WORD;
    end else if (rd_addr == `SPI_STATUS_ADDR) begin
      // Status is passed through live, not sampled.
      rd_data = status;
    end else begin
      rd_data = regs[rd_addr];
    end
  end

endmodule

//--- logic/spi_slave_consts.svh
// Shared constants for the SPI register slave.
// Frame and address widths, register map addresses, ID word and reset value.

`ifndef SPI_SLAVE_CONSTS_SVH
`define SPI_SLAVE_CONSTS_SVH

// Every SPI frame is one 16-bit word, the same width as a register.
`define SPI_DATA_W 16

// Four address bits select one of the registers.
`define SPI_ADDR_W 4

// Total number of addressable registers.
`define SPI_REG_N 16

// The two top addresses are read-only.
`define SPI_STATUS_ADDR 4'd14
`define SPI_ID_ADDR 4'd15

// Value returned by the identification register.
`define SPI_ID_WORD 16'h5A17

// Value held by the general registers after reset.
`define SPI_REG_RST 16'h0000

`endif

//--- logic/spi_slave_pkg.sv
// Types shared by the SPI register slave.
// Command word, register write request and protocol FSM states.

package spi_slave_pkg;

`include "spi_slave_consts.svh"

  // Command frame contents.
  // The read flag sits directly above the address, so the low five bits of the
  // received command frame map onto this struct as they are.
  typedef struct packed {
    logic                   rd;
    logic [`SPI_ADDR_W-1:0] addr;
  } spi_cmd_t;

  // Write request from the protocol FSM to the register bank.
  // The bank commits data on the clock edge after en is seen high.
  typedef struct packed {
    logic                   en;
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_DATA_W-1:0] data;
  } reg_wr_t;

  // Protocol FSM states.
  // proto_idle waits for a command frame to finish.
  // proto_cmd holds a decoded command until the data frame finishes.
  // proto_data waits for the next chip-select fall before going idle again.
  typedef enum logic [1:0] {
    proto_idle = 2'd0,
    proto_cmd  = 2'd1,
    proto_data = 2'd2
  } proto_state_t;

endpackage

//--- logic/spi_slave_top.sv
// Top level of the SPI register slave.
// Connects the frame shifter, the protocol FSM and the register bank.

`timescale 1ns/1ns

`include "spi_slave_consts.svh"

module spi_slave_top
  import spi_slave_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   sclk,
  input  logic                   ss,
  input  logic                   mosi,
  input  logic [`SPI_DATA_W-1:0] status,
  output logic                   miso
);

  // Frame level signals between shifter and protocol.
  logic [`SPI_DATA_W-1:0] rx_frame;
  logic [`SPI_DATA_W-1:0] tx_frame;
  logic                   ss_rise;
  logic                   ss_fall;

  // Register access between protocol and bank.
  logic [`SPI_ADDR_W-1:0] rd_addr;
  logic [`SPI_DATA_W-1:0] rd_data;
  reg_wr_t                wr;

  // Serial side. All SPI pins end here.
  spi_frame_shifter u_shifter (
    .clk      (clk),
    .rst      (rst),
    .sclk     (sclk),
    .ss       (ss),
    .mosi     (mosi),
    .tx_frame (tx_frame),
    .miso     (miso),
    .rx_frame (rx_frame),
    .ss_rise  (ss_rise),
    .ss_fall  (ss_fall)
  );

  spi_protocol u_protocol (
    .clk      (clk),
    .rst      (rst),
    .rx_frame (rx_frame),
    .ss_rise  (ss_rise),
    .ss_fall  (ss_fall),
    .rd_data  (rd_data),
    .tx_frame (tx_frame),
    .rd_addr  (rd_addr),
    .wr       (wr)
  );

  spi_reg_bank u_bank (
    .clk     (clk),
    .rst     (rst),
    .wr      (wr),
    .rd_addr (rd_addr),
    .status  (status),
    .rd_data (rd_data)
  );

endmodule
